//--- hw/lsp_lsf_pkg.sv
`default_nettype none

package lsp_lsf_pkg;

	//////////////////////////////////////////////////////////////////////
	// Word types
	//////////////////////////////////////////////////////////////////////

	// Q15 sample, LSP, LSF or table entry
	typedef logic [15:0] word16;
	// Long accumulator or memory word
	typedef logic [31:0] word32;
	typedef logic [11:0] mem_addr;
	typedef logic [4:0] shift_amount;

	//////////////////////////////////////////////////////////////////////
	// Sizes and memory map
	//////////////////////////////////////////////////////////////////////

	localparam int lsp_order = 10;
	localparam int table_size = 64;

	// Constant memory
	localparam mem_addr table_base = 12'd0;
	localparam mem_addr slope_base = 12'd64;

	// Scratch memory
	localparam mem_addr lsp_base = 12'd32;

	// Converter FSM
	typedef enum logic [3:0] {
		idle,
		fetch_table,
		fetch_lsp,
		compare,
		step_down,
		refetch_lsp,
		load_lsp,
		diff,
		multiply,
		shift_wait,
		next_lsp
	} conv_state;

endpackage

`default_nettype wire

//--- hw/lsp_lsf_if.sv
`timescale 1ns/1ns
`default_nettype none

// Scratch memory port, read data one cycle after read_addr
interface scratch_port import lsp_lsf_pkg::*; ();
	mem_addr read_addr;
	mem_addr write_addr;
	word32 write_data;
	logic write_en;
	word32 read_data;

	modport converter (output read_addr, write_addr, write_data, write_en, input read_data);
	modport memory (input read_addr, write_addr, write_data, write_en, output read_data);
endinterface

// Operands out, results back in the same cycle
interface op_bank import lsp_lsf_pkg::*; ();
	word16 add_a, add_b, add_y;
	word16 sub_a, sub_b, sub_y;
	word16 shl_a, shl_b, shl_y;
	word32 l_add_a, l_add_b, l_add_y;
	word16 l_mult_a, l_mult_b;
	word32 l_mult_y;

	modport client (
		output add_a, add_b, sub_a, sub_b, shl_a, shl_b, l_add_a, l_add_b, l_mult_a, l_mult_b,
		input add_y, sub_y, shl_y, l_add_y, l_mult_y
	);
	modport ops (
		input add_a, add_b, sub_a, sub_b, shl_a, shl_b, l_add_a, l_add_b, l_mult_a, l_mult_b,
		output add_y, sub_y, shl_y, l_add_y, l_mult_y
	);
endinterface

// Long shift, start pulse in, done pulse with result back
interface shift_port import lsp_lsf_pkg::*; ();
	logic start;
	word32 value;
	shift_amount amount;
	word32 result;
	logic done;

	modport client (output start, value, amount, input result, done);
	modport shifter (input start, value, amount, output result, done);
endinterface

`default_nettype wire

//--- hw/basic_ops.sv
`timescale 1ns/1ns
`default_nettype none

module basic_ops import lsp_lsf_pkg::*; (
	op_bank.ops ops
);

	// Clamp a 17-bit sum to the 16-bit range
	function automatic word16 sat16(input logic [16:0] wide);
		if (wide[16] != wide[15])
			return wide[16] ? 16'h8000 : 16'h7fff;
		return wide[15:0];
	endfunction

	logic [16:0] add_wide;
	logic [16:0] sub_wide;
	logic [31:0] shl_wide;
	logic [32:0] l_add_wide;
	logic signed [31:0] product;
	word16 shl_sat;

	assign add_wide = {ops.add_a[15], ops.add_a} + {ops.add_b[15], ops.add_b};
	assign sub_wide = {ops.sub_a[15], ops.sub_a} - {ops.sub_b[15], ops.sub_b};
	assign ops.add_y = sat16(add_wide);
	assign ops.sub_y = sat16(sub_wide);

	//////////////////////////////////////////////////////////////////////
	// shl, counts above 15 saturate any nonzero input
	//////////////////////////////////////////////////////////////////////
	assign shl_wide = {{16{ops.shl_a[15]}}, ops.shl_a} << ops.shl_b[3:0];
	assign shl_sat = ops.shl_a[15] ? 16'h8000 : 16'h7fff;

	always_comb begin
		if (ops.shl_b > 16'd15)
			ops.shl_y = (ops.shl_a == '0) ? '0 : shl_sat;
		else if (shl_wide[31:15] != {17{shl_wide[15]}})
			ops.shl_y = shl_sat;
		else
			ops.shl_y = shl_wide[15:0];
	end

	// 32-bit saturating add
	assign l_add_wide = {ops.l_add_a[31], ops.l_add_a} + {ops.l_add_b[31], ops.l_add_b};
	assign ops.l_add_y = (l_add_wide[32] != l_add_wide[31]) ?
		(l_add_wide[32] ? 32'h8000_0000 : 32'h7fff_ffff) : l_add_wide[31:0];

	// Fractional multiply, only -1 * -1 overflows
	assign product = $signed({{16{ops.l_mult_a[15]}}, ops.l_mult_a}) *
		$signed({{16{ops.l_mult_b[15]}}, ops.l_mult_b});
	assign ops.l_mult_y = (ops.l_mult_a == 16'h8000 && ops.l_mult_b == 16'h8000) ?
		32'h7fff_ffff : {product[30:0], 1'b0};

endmodule

`default_nettype wire

//--- hw/long_shift_left.sv
`timescale 1ns/1ns
`default_nettype none

module long_shift_left import lsp_lsf_pkg::*; (
	input logic clock,
	input logic reset,
	shift_port.shifter shift
);

	logic busy;
	shift_amount count;
	word32 acc;

	// Bits still to shift, done when it reaches zero
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
		end else if (shift.start) begin
			busy <= 1'b1;
			count <= shift.amount;
		end else if (busy) begin
			if (count == '0)
				busy <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	// One bit per cycle, a saturated value shifts back onto itself
	always_ff @(posedge clock) begin
		if (shift.start) begin
			acc <= shift.value;
		end else if (busy && count != '0) begin
			if (acc[31] != acc[30])
				acc <= acc[31] ? 32'h8000_0000 : 32'h7fff_ffff;
			else
				acc <= {acc[30:0], 1'b0};
		end
	end

	assign shift.done = busy && (count == '0);
	assign shift.result = acc;

endmodule

`default_nettype wire

//--- hw/word_ram.sv
`timescale 1ns/1ns
`default_nettype none

module word_ram import lsp_lsf_pkg::*; #(
	parameter int addr_bits = 11
) (
	input logic clock,
	input mem_addr read_addr,
	input mem_addr write_addr,
	input logic write_en,
	input word32 write_data,
	output word32 read_data
);

	word32 mem [2**addr_bits];

	// Read returns the old word on a same-address write
	always_ff @(posedge clock) begin
		if (write_en)
			mem[write_addr[addr_bits-1:0]] <= write_data;
		read_data <= mem[read_addr[addr_bits-1:0]];
	end

endmodule

`default_nettype wire

//--- hw/lsp_lsf.sv
`timescale 1ns/1ns
`default_nettype none

module lsp_lsf import lsp_lsf_pkg::*; (
	input logic clock,
	input logic reset,
	input logic start,
	input mem_addr lsf_base,
	output logic done,
	output mem_addr const_addr,
	input word32 const_data,
	scratch_port.converter mem,
	op_bank.client ops,
	shift_port.client shift
);

	conv_state state, state_next;
	logic [5:0] index, index_next;
	logic [3:0] lsp_count, lsp_count_next;
	word16 temp, temp_next;

	mem_addr table_addr;
	mem_addr slope_addr;
	mem_addr lsp_addr;
	mem_addr lsf_addr;

	assign table_addr = table_base + mem_addr'(index);
	assign slope_addr = slope_base + mem_addr'(index);
	assign lsp_addr = lsp_base + mem_addr'(lsp_count);
	assign lsf_addr = lsf_base + mem_addr'(lsp_count);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			index <= 6'(table_size - 1);
			lsp_count <= 4'(lsp_order - 1);
		end else begin
			state <= state_next;
			index <= index_next;
			lsp_count <= lsp_count_next;
		end
	end

	// Holds table entry, LSP or difference
	always_ff @(posedge clock)
		temp <= temp_next;

	//////////////////////////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		state_next = state;
		index_next = index;
		lsp_count_next = lsp_count;
		temp_next = temp;

		done = 1'b0;
		const_addr = '0;
		mem.read_addr = '0;
		mem.write_addr = '0;
		mem.write_data = '0;
		mem.write_en = 1'b0;

		ops.add_a = '0;
		ops.add_b = '0;
		ops.sub_a = '0;
		ops.sub_b = '0;
		ops.shl_a = '0;
		ops.shl_b = '0;
		ops.l_add_a = '0;
		ops.l_add_b = '0;
		ops.l_mult_a = '0;
		ops.l_mult_b = '0;

		shift.start = 1'b0;
		shift.value = '0;
		shift.amount = '0;

		case (state)
			idle: begin
				if (start)
					state_next = fetch_table;
			end
			fetch_table: begin
				const_addr = table_addr;
				state_next = fetch_lsp;
			end
			fetch_lsp: begin
				temp_next = const_data[15:0];
				mem.read_addr = lsp_addr;
				state_next = compare;
			end
			compare: begin
				// Table entry below the LSP means keep searching
				ops.sub_a = temp;
				ops.sub_b = mem.read_data[15:0];
				if (!ops.sub_y[15] || index == '0) begin
					mem.read_addr = lsp_addr;
					state_next = refetch_lsp;
				end else begin
					state_next = step_down;
				end
			end
			step_down: begin
				// Next table entry read issued along with the decrement
				ops.sub_a = {10'd0, index};
				ops.sub_b = 16'd1;
				index_next = ops.sub_y[5:0];
				const_addr = table_base + mem_addr'(ops.sub_y[5:0]);
				state_next = fetch_lsp;
			end
			refetch_lsp: begin
				mem.read_addr = lsp_addr;
				state_next = load_lsp;
			end
			load_lsp: begin
				temp_next = mem.read_data[15:0];
				const_addr = table_addr;
				state_next = diff;
			end
			diff: begin
				ops.sub_a = temp;
				ops.sub_b = const_data[15:0];
				temp_next = ops.sub_y;
				const_addr = slope_addr;
				state_next = multiply;
			end
			multiply: begin
				ops.l_mult_a = temp;
				ops.l_mult_b = const_data[15:0];
				shift.start = 1'b1;
				shift.value = ops.l_mult_y;
				shift.amount = shift_amount'(3);
				state_next = shift_wait;
			end
			shift_wait: begin
				if (shift.done) begin
					// Round, then add the index in Q8
					ops.l_add_a = shift.result;
					ops.l_add_b = 32'h0000_8000;
					ops.add_a = ops.l_add_y[31:16];
					ops.shl_a = {10'd0, index};
					ops.shl_b = 16'd8;
					ops.add_b = ops.shl_y;
					mem.write_addr = lsf_addr;
					mem.write_data = {16'd0, ops.add_y};
					mem.write_en = 1'b1;
					state_next = next_lsp;
				end
			end
			next_lsp: begin
				if (lsp_count == '0) begin
					done = 1'b1;
					lsp_count_next = 4'(lsp_order - 1);
					index_next = 6'(table_size - 1);
					state_next = idle;
				end else begin
					lsp_count_next = lsp_count - 1'b1;
					state_next = fetch_table;
				end
			end
			default: state_next = idle;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/lsp_lsf_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsp_lsf_top import lsp_lsf_pkg::*; (
	input logic clock,
	input logic reset,
	input logic start,
	input mem_addr lsf_base,
	output logic done,
	input logic host_write_en,
	input logic host_sel,
	input mem_addr host_addr,
	input word32 host_write_data,
	output word32 host_read_data
);

	scratch_port scratch_if ();
	op_bank ops_if ();
	shift_port shift_if ();

	mem_addr const_addr;
	word32 const_data;
	logic busy;
	logic host_scratch_write;
	logic host_const_write;

	// Run in progress, host owns the scratch read port otherwise
	always_ff @(posedge clock) begin
		if (reset)
			busy <= 1'b0;
		else if (done)
			busy <= 1'b0;
		else if (start)
			busy <= 1'b1;
	end

	assign host_scratch_write = host_write_en && !host_sel;
	assign host_const_write = host_write_en && host_sel;

	lsp_lsf converter (
		.clock(clock),
		.reset(reset),
		.start(start),
		.lsf_base(lsf_base),
		.done(done),
		.const_addr(const_addr),
		.const_data(const_data),
		.mem(scratch_if.converter),
		.ops(ops_if.client),
		.shift(shift_if.client)
	);

	basic_ops op_unit (.ops(ops_if.ops));

	long_shift_left shifter (.clock(clock), .reset(reset), .shift(shift_if.shifter));

	//////////////////////////////////////////////////////////////////////
	// Memories
	//////////////////////////////////////////////////////////////////////
	word_ram #(.addr_bits(11)) scratch_ram (
		.clock(clock),
		.read_addr(busy ? scratch_if.read_addr : host_addr),
		.write_addr(host_scratch_write ? host_addr : scratch_if.write_addr),
		.write_en(host_scratch_write || scratch_if.write_en),
		.write_data(host_scratch_write ? host_write_data : scratch_if.write_data),
		.read_data(scratch_if.read_data)
	);

	assign host_read_data = scratch_if.read_data;

	// Cosine table and slopes, written by the host only
	word_ram #(.addr_bits(7)) const_ram (
		.clock(clock),
		.read_addr(const_addr),
		.write_addr(host_addr),
		.write_en(host_const_write),
		.write_data(host_write_data),
		.read_data(const_data)
	);

endmodule

`default_nettype wire

//--- tb/lsp_lsf_model.svh
`ifndef LSP_LSF_MODEL_SVH
`define LSP_LSF_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Saturating arithmetic on wide integers
//////////////////////////////////////////////////////////////////////

function automatic longint from_word16(input word16 w);
	return longint'($signed(w));
endfunction

function automatic longint from_word32(input word32 w);
	return longint'($signed(w));
endfunction

function automatic word16 clamp16(input longint v);
	if (v > 32767)
		return 16'h7fff;
	if (v < -32768)
		return 16'h8000;
	return word16'(v);
endfunction

function automatic word32 clamp32(input longint v);
	if (v > 64'sd2147483647)
		return 32'h7fff_ffff;
	if (v < -64'sd2147483648)
		return 32'h8000_0000;
	return word32'(v);
endfunction

//////////////////////////////////////////////////////////////////////
// Search and interpolate, LSP 9 first, index carried between LSPs
//////////////////////////////////////////////////////////////////////

task automatic convert_model();
	int idx;
	longint diff;
	longint acc;
	idx = table_size - 1;
	for (int k = lsp_order - 1; k >= 0; k--) begin
		while (idx > 0 && from_word16(cos_table[idx]) < from_word16(lsp_in[k]))
			idx--;
		diff = from_word16(clamp16(from_word16(lsp_in[k]) - from_word16(cos_table[idx])));
		// Fractional product, then three saturating doublings
		acc = from_word32(clamp32(2 * diff * from_word16(slope_table[idx])));
		for (int n = 0; n < 3; n++)
			acc = from_word32(clamp32(acc * 2));
		acc = from_word32(clamp32(acc + 32768));
		lsf_exp[k] = clamp16((acc >>> 16) + idx * 256);
	end
endtask

`endif

//--- tb/lsp_lsf_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lsp_lsf_tb import lsp_lsf_pkg::*; ();

	localparam int scratch_words = 2048;
	localparam int run_limit = 2000;
	localparam int quiet_cycles = 400;

	logic clock;
	logic reset;
	logic start;
	mem_addr lsf_base;
	logic done;
	logic host_write_en;
	logic host_sel;
	mem_addr host_addr;
	word32 host_write_data;
	word32 host_read_data;

	word16 cos_table [table_size];
	word16 slope_table [table_size];
	word16 lsp_in [lsp_order];
	word16 lsf_exp [lsp_order];
	// Expected contents of the whole scratch memory
	word32 scratch_image [scratch_words];

	`include "lsp_lsf_model.svh"

	lsp_lsf_top UUT (
		.clock(clock),
		.reset(reset),
		.start(start),
		.lsf_base(lsf_base),
		.done(done),
		.host_write_en(host_write_en),
		.host_sel(host_sel),
		.host_addr(host_addr),
		.host_write_data(host_write_data),
		.host_read_data(host_read_data)
	);

	always #10 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Failure handling and compares
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_failure();
		$display("Test FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_word16(input word16 got, input word16 expected, input string what);
		if (got !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			stop_on_failure();
		end
	endtask

	task automatic check_word32(input word32 got, input word32 expected, input string what);
		if (got !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			stop_on_failure();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host port
	//////////////////////////////////////////////////////////////////////

	task automatic host_write(input logic sel, input mem_addr addr, input word32 data);
		@(posedge clock);
		host_write_en <= 1'b1;
		host_sel <= sel;
		host_addr <= addr;
		host_write_data <= data;
	endtask

	task automatic host_release();
		@(posedge clock);
		host_write_en <= 1'b0;
	endtask

	// Data comes back one cycle after the address
	task automatic host_read(input mem_addr addr, output word32 data);
		@(posedge clock);
		host_addr <= addr;
		@(posedge clock);
		@(negedge clock);
		data = host_read_data;
	endtask

	task automatic fill_scratch();
		word32 data;
		for (int a = 0; a < scratch_words; a++) begin
			data = 32'h6b00_0000 ^ (word32'(a) * 32'h0001_0401);
			scratch_image[a] = data;
			host_write(1'b0, mem_addr'(a), data);
		end
		host_release();
	endtask

	task automatic sweep_scratch();
		word32 got;
		for (int a = 0; a < scratch_words; a++) begin
			host_read(mem_addr'(a), got);
			check_word32(got, scratch_image[a], $sformatf("scratch word %0d", a));
		end
	endtask

	// Mode 0 random, 1 both search ends, 2 saturation
	task automatic make_stimulus(input int mode);
		int level;
		int step_max;
		word32 data;
		level = (mode == 1) ? 30000 : 32767;
		step_max = (mode == 2) ? 400 : 900;
		for (int i = 0; i < table_size; i++) begin
			cos_table[i] = word16'(level);
			level -= 1 + int'($urandom % step_max);
			if (mode == 2 && ($urandom % 2 == 0 || i == table_size - 1))
				slope_table[i] = ($urandom % 2 == 0 || i == table_size - 1) ? 16'h8000 : 16'h7fff;
			else
				slope_table[i] = word16'($urandom);
			host_write(1'b1, table_base + mem_addr'(i), {word16'($urandom), cos_table[i]});
			host_write(1'b1, slope_base + mem_addr'(i), {word16'($urandom), slope_table[i]});
		end
		level = 32000 - int'($urandom % 2000);
		for (int k = 0; k < lsp_order; k++) begin
			lsp_in[k] = word16'(level);
			level -= 1 + int'($urandom % 6000);
		end
		if (mode == 1)
			lsp_in[0] = 16'h7fff;
		if (mode != 0)
			lsp_in[lsp_order - 1] = 16'h8000;
		for (int k = 0; k < lsp_order; k++) begin
			data = {word16'($urandom), lsp_in[k]};
			scratch_image[int'(lsp_base) + k] = data;
			host_write(1'b0, lsp_base + mem_addr'(k), data);
		end
		host_release();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////////////////////////

	// Negative second_start means a single start pulse
	task automatic run_conversion(input mem_addr base, input int second_start);
		int cycles;
		int pulses;
		@(posedge clock);
		start <= 1'b1;
		lsf_base <= base;
		cycles = 0;
		pulses = 0;
		while (pulses == 0 && cycles < run_limit) begin
			@(posedge clock);
			start <= (cycles == second_start);
			@(negedge clock);
			if (done)
				pulses++;
			cycles++;
		end
		if (pulses == 0) begin
			$display("Timeout: no done pulse within %0d cycles of start", run_limit);
			stop_on_failure();
		end
		// Any further done means a repeated pulse or a restarted run
		for (int n = 0; n < quiet_cycles; n++) begin
			@(negedge clock);
			if (done) begin
				$display("Done pulsed more than once for one run at %0t ns", $time);
				stop_on_failure();
			end
		end
	endtask

	task automatic check_results(input mem_addr base);
		word32 got;
		int slot;
		for (int k = 0; k < lsp_order; k++) begin
			host_read(base + mem_addr'(k), got);
			check_word16(got[15:0], lsf_exp[k], $sformatf("LSF %0d", k));
			check_word16(got[31:16], 16'h0000, $sformatf("upper half of LSF %0d", k));
			slot = (int'(base) + k) % scratch_words;
			scratch_image[slot] = {16'h0000, lsf_exp[k]};
		end
	endtask

	initial begin
		mem_addr base;
		int gap;
		int mode;
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		lsf_base = '0;
		host_write_en = 1'b0;
		host_sel = 1'b0;
		host_addr = '0;
		host_write_data = '0;
		void'($urandom(87));

		repeat (10) @(posedge clock);
		reset <= 1'b0;

		// Idle converter stays quiet
		for (int n = 0; n < 20; n++) begin
			@(negedge clock);
			if (done) begin
				$display("Done went high without a start at %0t ns", $time);
				stop_on_failure();
			end
		end

		fill_scratch();
		sweep_scratch();

		// Twenty random runs, then search ends, then saturation
		for (int run = 0; run < 24; run++) begin
			mode = (run < 20) ? 0 : ((run < 22) ? 1 : 2);
			make_stimulus(mode);
			base = mem_addr'(64 + $urandom % 1900);
			gap = (run % 2 == 1) ? 5 + int'($urandom % 60) : -1;
			run_conversion(base, gap);
			convert_model();
			check_results(base);
		end

		sweep_scratch();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+tb
hw/lsp_lsf_pkg.sv
hw/lsp_lsf_if.sv
hw/basic_ops.sv
hw/long_shift_left.sv
hw/word_ram.sv
hw/lsp_lsf.sv
hw/lsp_lsf_top.sv
tb/lsp_lsf_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LSP to LSF testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module lsp_lsf_tb -o lsp_lsf_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/lsp_lsf_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
